//--- hdl/mont_pkg.sv
// Shared sizes, modulus constants, bus and redundant types for the squaring engine; compile first.
package mont_pkg;

  // operand geometry.
  localparam int NUM_WRDS = 4;
  localparam int WRD_BITS = 16;
  localparam int DAT_BITS = NUM_WRDS * WRD_BITS;
  localparam int CNT_BITS = 16;

  // column accumulator, four partial products plus add term and carry.
  localparam int COL_BITS = 2 * (WRD_BITS + 1) + 4;

  // modulus 2^62 - 2^32 - 1, odd and small enough that 4P < R.
  localparam logic [DAT_BITS-1:0] P = 64'h3FFF_FFFE_FFFF_FFFF;
  // -P^-1 mod R.
  localparam logic [DAT_BITS-1:0] MONT_FACTOR = 64'h3FFF_FFFF_0000_0001;

  // register map, byte offsets.
  localparam int APB_ADDR_BITS = 5;
  localparam int APB_DATA_BITS = 32;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_X_LO   = 5'd0;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_X_HI   = 5'd4;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_COUNT  = 5'd8;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_CTRL   = 5'd12;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_RES_LO = 5'd16;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_RES_HI = 5'd20;
  localparam logic [APB_ADDR_BITS-1:0] ADDR_STATUS = 5'd24;

  // word 0 is least significant, bit WRD_BITS of each word is the spare carry.
  typedef logic [NUM_WRDS-1:0][WRD_BITS:0]   redun0_t;
  typedef logic [2*NUM_WRDS-1:0][WRD_BITS:0] redun1_t;
  typedef logic [COL_BITS-1:0]               col_t;

  typedef enum logic [1:0] {
    MODE_SQ  = 2'd0,
    MODE_LO  = 2'd1,
    MODE_RED = 2'd2
  } mult_mode_t;

  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
  } apb_rsp_t;

  function automatic redun0_t to_redun(input logic [DAT_BITS-1:0] v);
    redun0_t r;
    for (int i = 0; i < NUM_WRDS; i++) begin
      r[i] = {1'b0, v[i*WRD_BITS +: WRD_BITS]};
    end
    return r;
  endfunction

  // weighted sum of the words, two extra bits for the spare carries.
  function automatic logic [DAT_BITS+1:0] redun_value(input redun0_t r);
    logic [DAT_BITS+1:0] acc;
    acc = '0;
    for (int i = 0; i < NUM_WRDS; i++) begin
      acc = acc + ((DAT_BITS + 2)'(r[i]) << (i * WRD_BITS));
    end
    return acc;
  endfunction

endpackage

//--- hdl/mont_apb_regs.sv
// APB register block for operand, count, control, status and result; sits between bus and engine.
`timescale 1ns/1ps

module mont_apb_regs (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  mont_pkg::apb_req_t            i_apb,
  output mont_pkg::apb_rsp_t            o_apb,
  input  logic                          i_res_val,
  input  logic [mont_pkg::DAT_BITS-1:0] i_result,
  output logic                          o_start,
  output mont_pkg::redun0_t             o_x,
  output logic [mont_pkg::CNT_BITS-1:0] o_count,
  output logic                          o_irq
);

  logic                               access;
  logic                               addr_ok;
  logic                               wr_ro;
  logic                               start_req;
  logic                               err;
  logic                               wr;
  logic                               busy;
  logic                               done;
  logic [mont_pkg::APB_DATA_BITS-1:0] x_lo;
  logic [mont_pkg::APB_DATA_BITS-1:0] x_hi;
  logic [mont_pkg::APB_DATA_BITS-1:0] rdata;
  logic [mont_pkg::CNT_BITS-1:0]      count_r;
  logic [mont_pkg::DAT_BITS-1:0]      result;

  assign access = i_apb.psel && i_apb.penable;

  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (i_apb.paddr)
      mont_pkg::ADDR_X_LO:   rdata = x_lo;
      mont_pkg::ADDR_X_HI:   rdata = x_hi;
      mont_pkg::ADDR_COUNT:  rdata = {{(mont_pkg::APB_DATA_BITS-mont_pkg::CNT_BITS){1'b0}}, count_r};
      // start bit self-clears, reads back zero.
      mont_pkg::ADDR_CTRL:   rdata = '0;
      mont_pkg::ADDR_RES_LO: rdata = result[mont_pkg::APB_DATA_BITS-1:0];
      mont_pkg::ADDR_RES_HI: rdata = result[mont_pkg::DAT_BITS-1:mont_pkg::APB_DATA_BITS];
      mont_pkg::ADDR_STATUS: rdata = {29'd0, o_irq, done, busy};
      default:               addr_ok = 1'b0;
    endcase
  end

  // result registers are read only.
  assign wr_ro = i_apb.pwrite &&
                 (i_apb.paddr == mont_pkg::ADDR_RES_LO || i_apb.paddr == mont_pkg::ADDR_RES_HI);
  assign start_req = i_apb.pwrite && i_apb.paddr == mont_pkg::ADDR_CTRL && i_apb.pwdata[0];
  assign err       = !addr_ok || wr_ro || (start_req && busy);
  assign wr        = access && i_apb.pwrite && !err;
  assign o_start   = wr && start_req;

  assign o_apb.prdata  = rdata;
  assign o_apb.pready  = 1'b1;
  assign o_apb.pslverr = access && err;

  assign o_x     = mont_pkg::to_redun({x_hi, x_lo});
  assign o_count = count_r;

  always_ff @(posedge i_clk) begin
    if (wr && i_apb.paddr == mont_pkg::ADDR_X_LO)
      x_lo <= i_apb.pwdata;
    if (wr && i_apb.paddr == mont_pkg::ADDR_X_HI)
      x_hi <= i_apb.pwdata;
    if (wr && i_apb.paddr == mont_pkg::ADDR_COUNT)
      count_r <= i_apb.pwdata[mont_pkg::CNT_BITS-1:0];
    if (i_res_val)
      result <= i_result;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      done  <= 1'b0;
      o_irq <= 1'b0;
    end else begin
      if (o_start) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (i_res_val) begin
        busy  <= 1'b0;
        done  <= 1'b1;
        o_irq <= 1'b1;
      end
      // write one to status bit 1 clears the interrupt.
      if (wr && i_apb.paddr == mont_pkg::ADDR_STATUS && i_apb.pwdata[1])
        o_irq <= 1'b0;
    end
  end

  // a start is a single pulse and leaves the block busy.
  a_start_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    o_start |=> busy && !o_start);

endmodule

//--- hdl/mont_sq_ctrl.sv
// One-hot sequencer for the squaring loop; drives multiplier mode and flags completion.
`timescale 1ns/1ps

module mont_sq_ctrl (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_start,
  input  logic [mont_pkg::CNT_BITS-1:0] i_count,
  output mont_pkg::mult_mode_t          o_mode,
  output logic                          o_sel_load,
  output logic                          o_done
);

  // bit positions of the one-hot state vector.
  typedef enum int {
    S_IDLE = 0,
    S_LOAD = 1,
    S_SQ   = 2,
    S_LO   = 3,
    S_RED  = 4
  } state_idx_e;

  logic [4:0]                    state;
  logic [4:0]                    next_state;
  logic [mont_pkg::CNT_BITS-1:0] cnt;

  always_comb begin
    next_state = '0;
    unique case (1'b1)
      state[S_IDLE]: begin
        if (i_start)
          next_state[S_LOAD] = 1'b1;
        else
          next_state[S_IDLE] = 1'b1;
      end
      state[S_LOAD]: begin
        // zero iterations just resolves the operand.
        if (cnt == '0)
          next_state[S_IDLE] = 1'b1;
        else
          next_state[S_SQ] = 1'b1;
      end
      state[S_SQ]: next_state[S_LO] = 1'b1;
      state[S_LO]: next_state[S_RED] = 1'b1;
      state[S_RED]: begin
        if (cnt == 1)
          next_state[S_IDLE] = 1'b1;
        else
          next_state[S_SQ] = 1'b1;
      end
      default: next_state[S_IDLE] = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= '0;
      state[S_IDLE] <= 1'b1;
      cnt           <= '0;
      o_done        <= 1'b0;
    end else begin
      state  <= next_state;
      o_done <= (state[S_LOAD] || state[S_RED]) && next_state[S_IDLE];
      if (state[S_IDLE] && i_start)
        cnt <= i_count;
      else if (state[S_RED])
        cnt <= cnt - 1'b1;
    end
  end

  always_comb begin
    o_mode = mont_pkg::MODE_SQ;
    if (state[S_LO])
      o_mode = mont_pkg::MODE_LO;
    else if (state[S_RED])
      o_mode = mont_pkg::MODE_RED;
  end

  assign o_sel_load = state[S_LOAD];

  a_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
    $onehot(state));

  // the register block only starts an idle engine.
  a_start_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    i_start |-> state[S_IDLE]);

endmodule

//--- hdl/multi_mode_multiplier.sv
// Single-cycle word-array multiplier for square, low multiply and reduce steps of the loop.
`timescale 1ns/1ps

module multi_mode_multiplier (
  input  logic                 i_clk,
  input  mont_pkg::mult_mode_t i_mode,
  input  logic                 i_sel_load,
  input  mont_pkg::redun0_t    i_x,
  output mont_pkg::redun0_t    o_res
);

  mont_pkg::redun0_t                        mul_a;
  mont_pkg::redun0_t                        mul_b;
  mont_pkg::redun1_t                        add_term;
  mont_pkg::redun1_t                        prod;
  mont_pkg::redun1_t                        prod_r;
  mont_pkg::redun1_t                        add_r;
  mont_pkg::redun0_t                        res_r;
  mont_pkg::col_t [2*mont_pkg::NUM_WRDS-1:0] col;

  // operand and add term per mode.
  always_comb begin
    mul_a    = i_sel_load ? i_x : res_r;
    mul_b    = mul_a;
    add_term = '0;
    case (i_mode)
      mont_pkg::MODE_LO: begin
        mul_a = prod_r[mont_pkg::NUM_WRDS-1:0];
        mul_b = mont_pkg::to_redun(mont_pkg::MONT_FACTOR);
      end
      mont_pkg::MODE_RED: begin
        // m is the low product truncated mod R.
        mul_a = prod_r[mont_pkg::NUM_WRDS-1:0];
        mul_a[mont_pkg::NUM_WRDS-1][mont_pkg::WRD_BITS] = 1'b0;
        mul_b    = mont_pkg::to_redun(mont_pkg::P);
        add_term = add_r;
      end
      default: ;
    endcase
  end

  // schoolbook partial products summed per column.
  always_comb begin
    for (int k = 0; k < 2*mont_pkg::NUM_WRDS; k++) begin
      col[k] = mont_pkg::col_t'(add_term[k]);
    end
    for (int i = 0; i < mont_pkg::NUM_WRDS; i++) begin
      for (int j = 0; j < mont_pkg::NUM_WRDS; j++) begin
        col[i+j] = col[i+j] + mont_pkg::col_t'(mul_a[i]) * mont_pkg::col_t'(mul_b[j]);
      end
    end
  end

  // Low words are made canonical so the half split is exact and the
  // reduced low half is zero. High words keep their spare bit and pass
  // only the overflow above it on to the next word.
  always_comb begin
    mont_pkg::col_t sum;
    mont_pkg::col_t carry;
    carry = '0;
    for (int k = 0; k < 2*mont_pkg::NUM_WRDS; k++) begin
      sum = col[k] + carry;
      if (k < mont_pkg::NUM_WRDS) begin
        prod[k] = {1'b0, sum[mont_pkg::WRD_BITS-1:0]};
        carry   = sum >> mont_pkg::WRD_BITS;
      end else begin
        prod[k] = sum[mont_pkg::WRD_BITS:0];
        carry   = (sum >> (mont_pkg::WRD_BITS + 1)) << 1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    prod_r <= prod;
    // hold x^2 through the low multiply for the reduce step.
    if (i_mode == mont_pkg::MODE_LO)
      add_r <= prod_r;
    if (i_sel_load)
      res_r <= i_x;
    else if (i_mode == mont_pkg::MODE_RED)
      res_r <= prod[2*mont_pkg::NUM_WRDS-1:mont_pkg::NUM_WRDS];
  end

  // high half after reduce, below 2P.
  assign o_res = res_r;

endmodule

//--- hdl/redun_carry_resolve.sv
// Final stage that turns the redundant loop result into a canonical value below P.
`timescale 1ns/1ps

module redun_carry_resolve (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_val,
  input  mont_pkg::redun0_t             i_dat,
  output logic                          o_val,
  output logic [mont_pkg::DAT_BITS-1:0] o_result
);

  logic [mont_pkg::DAT_BITS+1:0] val;
  logic [mont_pkg::DAT_BITS+1:0] diff;
  logic [mont_pkg::DAT_BITS+1:0] p_wide;
  logic                          ge_p;

  assign p_wide = {2'b00, mont_pkg::P};

  // carry resolve by weighted sum.
  always_comb begin
    val  = mont_pkg::redun_value(i_dat);
    diff = val - p_wide;
    ge_p = val >= p_wide;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst)
      o_val <= 1'b0;
    else
      o_val <= i_val;
  end

  // one conditional subtract is enough below 2P.
  always_ff @(posedge i_clk) begin
    if (i_val) begin
      if (ge_p)
        o_result <= diff[mont_pkg::DAT_BITS-1:0];
      else
        o_result <= val[mont_pkg::DAT_BITS-1:0];
    end
  end

  // the multiplier keeps every reduced value under 2P.
  a_below_2p: assert property (@(posedge i_clk) disable iff (i_rst)
    i_val |-> val < (p_wide << 1));

endmodule

//--- hdl/mont_sq_top.sv
// Top level of the APB Montgomery squaring engine; connects registers, sequencer and datapath.
`timescale 1ns/1ps

module mont_sq_top (
  input  logic               i_clk,
  input  logic               i_rst,
  input  mont_pkg::apb_req_t i_apb,
  output mont_pkg::apb_rsp_t o_apb,
  output logic               o_irq
);

  logic                          start;
  mont_pkg::redun0_t             x_r;
  logic [mont_pkg::CNT_BITS-1:0] count_r;
  mont_pkg::mult_mode_t          mode;
  logic                          sel_load;
  logic                          done;
  mont_pkg::redun0_t             mul_res;
  logic                          res_val;
  logic [mont_pkg::DAT_BITS-1:0] result;

  mont_apb_regs u_regs (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_apb     (i_apb),
    .o_apb     (o_apb),
    .i_res_val (res_val),
    .i_result  (result),
    .o_start   (start),
    .o_x       (x_r),
    .o_count   (count_r),
    .o_irq     (o_irq)
  );

  mont_sq_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_start    (start),
    .i_count    (count_r),
    .o_mode     (mode),
    .o_sel_load (sel_load),
    .o_done     (done)
  );

  multi_mode_multiplier u_mult (
    .i_clk      (i_clk),
    .i_mode     (mode),
    .i_sel_load (sel_load),
    .i_x        (x_r),
    .o_res      (mul_res)
  );

  redun_carry_resolve u_resolve (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_val    (done),
    .i_dat    (mul_res),
    .o_val    (res_val),
    .o_result (result)
  );

endmodule

//--- testbench/mont_sq_tb.sv
// Self-checking testbench for the APB squaring engine; drives mont_sq_top over APB and scores results.
`timescale 1ns/1ps

module mont_sq_tb;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_TESTS  = 24;
  localparam int MAX_COUNT  = 40;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (3 * MAX_COUNT + 40) + 100;
  localparam logic [129:0] R_MASK = (130'd1 << 64) - 130'd1;

  logic               clk = 1'b0;
  logic               rst;
  mont_pkg::apb_req_t apb_req;
  mont_pkg::apb_rsp_t apb_rsp;
  logic               irq;

  integer      seed = 11619;
  logic [63:0] exp_q[$];
  logic [63:0] got_result;
  logic [63:0] exp_result;
  event        result_read;

  mont_sq_top dut (
    .i_clk (clk),
    .i_rst (rst),
    .i_apb (apb_req),
    .o_apb (apb_rsp),
    .o_irq (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x <- (x^2 + m*P) / R with m = (x^2 mod R) * MONT_FACTOR mod R.
  function automatic logic [63:0] ref_mont_sq(input logic [63:0] x0, input int n);
    logic [129:0] x;
    logic [129:0] sq;
    logic [129:0] m;
    x = {66'd0, x0};
    for (int i = 0; i < n; i++) begin
      sq = x * x;
      m  = ((sq & R_MASK) * mont_pkg::MONT_FACTOR) & R_MASK;
      x  = (sq + m * mont_pkg::P) >> 64;
    end
    x = x % mont_pkg::P;
    return x[63:0];
  endfunction

  function automatic mont_pkg::apb_rsp_t rsp_with(input logic err);
    mont_pkg::apb_rsp_t r;
    r = '0;
    r.pready  = 1'b1;
    r.pslverr = err;
    return r;
  endfunction

  function automatic logic [63:0] rand_operand();
    logic [63:0] v;
    v = {$random(seed), $random(seed)};
    return v % mont_pkg::P;
  endfunction

  task automatic check_result(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s: expected %h, got %h", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s: expected %b, got %b", $time, name, exp, act);
      $display("Verification failed");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic check_resp(input string name, input mont_pkg::apb_rsp_t exp,
                            input mont_pkg::apb_rsp_t act);
    if ({exp.pready, exp.pslverr} !== {act.pready, act.pslverr}) begin
      $display("[FAIL] %0t %s: expected pready/pslverr %b%b, got %b%b", $time, name,
               exp.pready, exp.pslverr, act.pready, act.pslverr);
      $display("Verification failed");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_latency(input int exp, input int act);
    if (exp != act) begin
      $display("[FAIL] %0t done latency: expected %0d, got %0d", $time, exp, act);
      $display("Verification failed");
      $fatal(1, "latency mismatch");
    end
  endtask

  // setup phase, access phase, then idle; response sampled mid access phase.
  task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output mont_pkg::apb_rsp_t rsp);
    mont_pkg::apb_req_t req;
    req        = '0;
    req.psel   = 1'b1;
    req.pwrite = wr;
    req.paddr  = addr;
    req.pwdata = wdata;
    @(posedge clk);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk);
    apb_req <= req;
    @(negedge clk);
    rsp   = apb_rsp;
    rdata = apb_rsp.prdata;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                           output mont_pkg::apb_rsp_t rsp);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, rsp);
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                          output mont_pkg::apb_rsp_t rsp);
    apb_xfer(1'b0, addr, 32'd0, data, rsp);
  endtask

  task automatic load_operand(input logic [63:0] x, input int n);
    mont_pkg::apb_rsp_t rsp;
    apb_write(mont_pkg::ADDR_X_LO, x[31:0], rsp);
    check_resp("pslverr x_lo write", rsp_with(1'b0), rsp);
    apb_write(mont_pkg::ADDR_X_HI, x[63:32], rsp);
    check_resp("pslverr x_hi write", rsp_with(1'b0), rsp);
    apb_write(mont_pkg::ADDR_COUNT, n, rsp);
    check_resp("pslverr count write", rsp_with(1'b0), rsp);
    exp_q.push_back(ref_mont_sq(x, n));
  endtask

  // counts edges after the start write until irq is seen high.
  task automatic wait_irq(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!irq) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic finish_case();
    mont_pkg::apb_rsp_t rsp;
    logic [31:0]        lo;
    logic [31:0]        hi;
    apb_read(mont_pkg::ADDR_STATUS, lo, rsp);
    check_bit("status.busy", 1'b0, lo[0]);
    check_bit("status.done", 1'b1, lo[1]);
    check_bit("status.irq", 1'b1, lo[2]);
    apb_read(mont_pkg::ADDR_RES_LO, lo, rsp);
    apb_read(mont_pkg::ADDR_RES_HI, hi, rsp);
    got_result = {hi, lo};
    -> result_read;
    apb_write(mont_pkg::ADDR_STATUS, 32'd2, rsp);
    @(negedge clk);
    check_bit("o_irq after clear", 1'b0, irq);
  endtask

  task automatic run_case(input logic [63:0] x, input int n);
    mont_pkg::apb_rsp_t rsp;
    int                 cycles;
    load_operand(x, n);
    apb_write(mont_pkg::ADDR_CTRL, 32'd1, rsp);
    check_resp("pslverr start write", rsp_with(1'b0), rsp);
    wait_irq(cycles);
    check_latency(3 * n + 3, cycles);
    finish_case();
  endtask

  // scoreboard, pairs each read result with the oldest expected value.
  always @(result_read) begin
    if (exp_q.size() == 0) begin
      $display("a result was read but no expected value was queued at %0t", $time);
      $display("Verification failed");
      $fatal(1, "scoreboard empty");
    end else begin
      exp_result = exp_q.pop_front();
      check_result("result", exp_result, got_result);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    mont_pkg::apb_rsp_t rsp;
    logic [31:0]        data;
    logic [63:0]        x;
    int                 n;
    int                 cycles;
    rst     = 1'b1;
    apb_req = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    apb_read(mont_pkg::ADDR_STATUS, data, rsp);
    check_bit("status.busy after reset", 1'b0, data[0]);
    check_bit("status.done after reset", 1'b0, data[1]);
    check_bit("o_irq after reset", 1'b0, irq);

    // operand in [P, 2P) to exercise the final subtract.
    run_case(rand_operand() + mont_pkg::P, 0);

    for (int i = 0; i < 20; i++) begin
      x = rand_operand();
      n = $unsigned($random(seed)) % MAX_COUNT + 1;
      run_case(x, n);
    end

    // second start while busy is refused.
    x = rand_operand();
    load_operand(x, MAX_COUNT);
    apb_write(mont_pkg::ADDR_CTRL, 32'd1, rsp);
    check_resp("pslverr start write", rsp_with(1'b0), rsp);
    apb_read(mont_pkg::ADDR_STATUS, data, rsp);
    check_bit("status.busy while running", 1'b1, data[0]);
    // a restart would pick up this new low half.
    apb_write(mont_pkg::ADDR_X_LO, ~x[31:0], rsp);
    check_resp("pslverr x_lo write while busy", rsp_with(1'b0), rsp);
    apb_write(mont_pkg::ADDR_CTRL, 32'd1, rsp);
    check_resp("pslverr start while busy", rsp_with(1'b1), rsp);
    wait_irq(cycles);
    finish_case();

    apb_read(5'd28, data, rsp);
    check_resp("pslverr unmapped read", rsp_with(1'b1), rsp);
    apb_write(mont_pkg::ADDR_RES_LO, 32'hFFFF_FFFF, rsp);
    check_resp("pslverr res_lo write", rsp_with(1'b1), rsp);
    apb_read(mont_pkg::ADDR_RES_LO, data, rsp);
    check_result("res_lo after write", {32'd0, exp_result[31:0]}, {32'd0, data});

    @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- mont_sq.f
hdl/mont_pkg.sv
hdl/mont_apb_regs.sv
hdl/mont_sq_ctrl.sv
hdl/multi_mode_multiplier.sv
hdl/redun_carry_resolve.sv
hdl/mont_sq_top.sv
testbench/mont_sq_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= mont_sq_tb
FILELIST  ?= mont_sq.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, exit status is the verdict"
	@echo "  clean  remove the obj_dir build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
